//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module sd_spi_tb \
  -f sd_spi.f \
  --Mdir obj_dir -o sd_spi_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sd_spi_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

//--- sd_block_fifo.sv
`default_nettype none

`include "sd_spi_config.svh"

module sd_block_fifo (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       clr_i,
  input  wire                       push_i,
  input  wire sd_spi_pkg::sd_word_t word_i,
  input  wire                       pop_i,
  output sd_spi_pkg::sd_word_t      word_o,
  output logic                      empty_o
);
  import sd_spi_pkg::*;

  localparam int DEPTH = `SD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  sd_word_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (count != (PTR_W + 1)'(DEPTH));
  assign do_pop  = pop_i && (count != '0);  // Pop on empty ignored
  assign word_o  = mem[rd_ptr];
  assign empty_o = (count == '0);

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= word_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst || clr_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sd_bus_regs.sv
`default_nettype none

module sd_bus_regs (
  input  wire                        clk,
  input  wire                        rst,
  input  wire sd_spi_pkg::bus_req_t  bus_i,
  input  wire                        done_i,
  input  wire sd_spi_pkg::sd_rsp_t   rsp_i,
  input  wire sd_spi_pkg::sd_word_t  fifo_word_i,
  input  wire                        fifo_empty_i,
  output sd_spi_pkg::bus_rsp_t       bus_o,
  output logic                       start_o,
  output sd_spi_pkg::sd_cmd_t        cmd_o,
  output logic                       pop_o
);
  import sd_spi_pkg::*;

  sd_cmd_t  cmd_q;
  logic     arrived_q;
  logic     busy_q;     // SEND in flight
  logic     ack_q;
  sd_word_t dat_q;
  sd_word_t rd_word;
  sd_word_t lane_mask;
  logic     req;

  function automatic sd_word_t sel_mask(sd_sel_t sel);
    sd_word_t m;
    for (int i = 0; i < 4; i++)
      m[i*8 +: 8] = {8{sel[i]}};
    return m;
  endfunction

  // No new request while acking or busy
  assign req       = bus_i.cyc && bus_i.stb && !ack_q && !busy_q;
  assign lane_mask = sel_mask(bus_i.sel);
  assign cmd_o     = cmd_q;
  assign bus_o     = '{ack: ack_q, dat: dat_q};

  always_comb
  begin
    case (bus_i.adr)
      CMD_LO:   rd_word = cmd_q[31:0];
      CMD_HI:   rd_word = cmd_q[63:32];
      RSP_FLAG: rd_word = {31'b0, arrived_q};
      RSP_LO:   rd_word = rsp_i[31:0];
      RSP_HI:   rd_word = {16'b0, rsp_i[47:32]};
      DATA:     rd_word = fifo_empty_i ? '0 : fifo_word_i;
      default:  rd_word = '0;  // NOOP, SEND, unmapped
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cmd_q     <= '0;
      arrived_q <= 1'b0;
      busy_q    <= 1'b0;
      ack_q     <= 1'b0;
      dat_q     <= '0;
      start_o   <= 1'b0;
      pop_o     <= 1'b0;
    end
    else
    begin
      ack_q   <= 1'b0;
      start_o <= 1'b0;
      pop_o   <= 1'b0;

      if (busy_q && done_i)
      begin
        busy_q    <= 1'b0;
        arrived_q <= 1'b1;
        ack_q     <= 1'b1;  // Delayed ack of the SEND write
        dat_q     <= '0;
      end

      if (req)
      begin
        dat_q <= rd_word & lane_mask;
        ack_q <= 1'b1;
        case (bus_i.adr)
          SEND:
            if (bus_i.we)
            begin
              ack_q     <= 1'b0;
              busy_q    <= 1'b1;
              start_o   <= 1'b1;
              arrived_q <= 1'b0;
            end
          CMD_LO:
            if (bus_i.we)
              cmd_q[31:0] <= (cmd_q[31:0] & ~lane_mask) | (bus_i.dat & lane_mask);
          CMD_HI:
            if (bus_i.we)
              cmd_q[63:32] <= (cmd_q[63:32] & ~lane_mask) | (bus_i.dat & lane_mask);
          DATA:
            if (!bus_i.we && !fifo_empty_i)
              pop_o <= 1'b1;  // Head already captured in dat_q
          default:
            ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- sd_card_model.sv
`default_nettype none

`include "sd_spi_config.svh"

module sd_card_model (
  input  wire         clk,
  input  wire         sck_i,
  input  wire         cs_i,
  input  wire         mosi_i,
  input  wire         data_en_i,
  input  wire         no_token_i,
  input  wire  [2:0]  rsp_len_i,
  output logic        miso_o,
  output logic [47:0] frame_o,
  output logic [47:0] rsp_o
);

  localparam int STREAM_MAX = 64 + `SD_BLOCK_BYTES * 8 + `SD_CRC_BITS;

  logic        sck_q;
  logic [47:0] shift_q;
  logic [31:0] lcg_q = 32'd72257;
  logic        tx [0:STREAM_MAX-1];
  logic [7:0]  blk [0:`SD_BLOCK_BYTES-1];
  int          cmd_cnt;
  int          tx_len;
  int          tx_ptr;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] next_byte();
    lcg_q = lcg_step(lcg_q);
    return lcg_q[23:16];
  endfunction

  // MSB first onto the MISO stream
  task automatic put_byte(input logic [7:0] b);
    for (int k = 7; k >= 0; k--)
    begin
      tx[tx_len] = b[k];
      tx_len++;
    end
  endtask

  task automatic build_stream();
    logic [47:0] acc;
    logic [7:0]  b;
    acc    = '0;
    tx_len = 0;
    tx_ptr = 0;
    put_byte(8'hFF);  // Ncr gap
    for (int i = 0; i < int'(rsp_len_i); i++)
    begin
      b = next_byte();
      if (i == 0)
        b[7] = 1'b0;  // Start bit
      acc = {acc[39:0], b};
      put_byte(b);
    end
    rsp_o <= acc;
    if (data_en_i && !no_token_i)
    begin
      put_byte(8'hFF);
      put_byte(8'hFE);
      for (int j = 0; j < `SD_BLOCK_BYTES; j++)
      begin
        b = next_byte();
        blk[j] = b;
        put_byte(b);
      end
      put_byte(next_byte());  // CRC, not checked
      put_byte(next_byte());
    end
  endtask

  always @(posedge clk)
  begin
    sck_q <= sck_i;
    if (cs_i)
    begin
      cmd_cnt = 0;
      tx_len  = 0;
      tx_ptr  = 0;
      miso_o <= 1'b1;
    end
    else if (sck_i && !sck_q)
    begin
      if (cmd_cnt < 48)
      begin
        shift_q = {shift_q[46:0], mosi_i};
        cmd_cnt++;
        if (cmd_cnt == 48)
        begin
          frame_o <= shift_q;
          build_stream();
        end
      end
    end
    else if (!sck_i && sck_q)
    begin
      if (tx_ptr < tx_len)
      begin
        miso_o <= tx[tx_ptr];
        tx_ptr++;
      end
      else
        miso_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- sd_spi.f
+incdir+.
sd_spi_pkg.sv
sd_spi_engine.sv
sd_block_fifo.sv
sd_bus_regs.sv
sd_spi_top.sv
sd_spi_tb_clk.sv
sd_card_model.sv
sd_spi_checker.sv
sd_spi_tb.sv

//--- sd_spi_checker.sv
`default_nettype none

module sd_spi_checker (
  input wire                       clk,
  input wire                       rst,
  input wire sd_spi_pkg::bus_req_t req_i,
  input wire sd_spi_pkg::bus_rsp_t rsp_i,
  input wire                       cs_i
);

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    rsp_i.ack |=> !rsp_i.ack)
    else $error("bus ack held high for two cycles");

  // Card only selected while a request is open
  cs_idle_high: assert property (@(posedge clk) disable iff (rst)
    !(req_i.cyc && req_i.stb) |-> cs_i)
    else $error("chip select low with no request pending");

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    rsp_i.ack |-> (req_i.cyc && req_i.stb))
    else $error("bus ack without cyc and stb");

endmodule

`default_nettype wire

//--- sd_spi_config.svh
`ifndef SD_SPI_CONFIG_SVH
`define SD_SPI_CONFIG_SVH

// Bit period is SD_SCK_DIV+1 clocks
`define SD_SCK_DIV 6

`define SD_CMD_BITS 48

`define SD_BLOCK_BYTES 512

`define SD_CRC_BITS 16

// Bit periods spent hunting for 0xFE
`define SD_TOKEN_TIMEOUT 511

`define SD_FIFO_DEPTH 128

`endif

//--- sd_spi_engine.sv
`default_nettype none

`include "sd_spi_config.svh"

module sd_spi_engine (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      start_i,
  input  wire sd_spi_pkg::sd_cmd_t cmd_i,
  input  wire                      miso_i,
  output logic                     done_o,
  output sd_spi_pkg::sd_rsp_t      rsp_o,
  output logic                     push_o,
  output sd_spi_pkg::sd_word_t     word_o,
  output logic                     fifo_clr_o,
  output logic                     sck_o,
  output logic                     cs_o,
  output logic                     mosi_o
);
  import sd_spi_pkg::*;

  localparam int DIV      = `SD_SCK_DIV;
  localparam int CNT_W    = $clog2(DIV + 1);
  localparam int CMD_BITS = `SD_CMD_BITS;
  localparam int BLK_BITS = `SD_BLOCK_BYTES * 8;
  localparam int END_BITS = BLK_BITS + `SD_CRC_BITS;
  localparam int BIT_W    = $clog2(END_BITS);
  localparam int TOK_W    = $clog2(`SD_TOKEN_TIMEOUT + 1);

  sd_state_e           state_q;
  logic [CNT_W-1:0]    sck_cnt;
  logic                bit_stb;
  logic [BIT_W-1:0]    bit_cnt;
  logic [BIT_W-1:0]    rsp_last;
  logic [TOK_W-1:0]    tok_cnt;
  logic [7:0]          hunt_q;
  logic [7:0]          hunt_nxt;
  logic [CMD_BITS-1:0] cmd_sr;
  sd_word_t            pack_q;
  logic                data_flag;

  assign bit_stb   = (sck_cnt == CNT_W'(DIV));
  assign data_flag = cmd_i[63];
  assign rsp_last  = BIT_W'({cmd_i[62:56], 3'b000}) - BIT_W'(1);
  assign hunt_nxt  = {hunt_q[6:0], miso_i};
  assign word_o    = pack_q;

  // Free running divider, SCK high mid period
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_cnt <= '0;
      sck_o   <= 1'b0;
    end
    else
    begin
      sck_cnt <= bit_stb ? '0 : sck_cnt + 1'b1;
      sck_o   <= (sck_cnt >= CNT_W'(DIV / 4)) && (sck_cnt < CNT_W'((3 * DIV) / 4));
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && start_i)
      cmd_sr <= cmd_i[CMD_BITS-1:0];
    else if (state_q == CMD && bit_stb)
      cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b1};
    // First byte lands in 7:0, MSB first within a byte
    if (state_q == BLOCK && bit_stb)
      pack_q[{bit_cnt[4:3], ~bit_cnt[2:0]}] <= miso_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= IDLE;
      cs_o       <= 1'b1;
      mosi_o     <= 1'b1;
      done_o     <= 1'b0;
      push_o     <= 1'b0;
      fifo_clr_o <= 1'b0;
      rsp_o      <= '0;
      bit_cnt    <= '0;
      tok_cnt    <= '0;
      hunt_q     <= '1;
    end
    else
    begin
      done_o     <= 1'b0;
      push_o     <= 1'b0;
      fifo_clr_o <= 1'b0;
      case (state_q)
        IDLE:
          if (start_i)
          begin
            rsp_o   <= '0;
            bit_cnt <= '0;
            state_q <= CMD;
          end
        CMD:
          if (bit_stb)
          begin
            if (bit_cnt == BIT_W'(CMD_BITS))
            begin
              mosi_o  <= 1'b1;  // Idle level while waiting
              state_q <= RSP_WAIT;
            end
            else
            begin
              cs_o    <= 1'b0;
              mosi_o  <= cmd_sr[CMD_BITS-1];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        RSP_WAIT:
          // Start bit is the first zero, already in rsp_o
          if (bit_stb && !miso_i)
          begin
            bit_cnt <= BIT_W'(1);
            state_q <= RSP;
          end
        RSP:
          if (bit_stb)
          begin
            rsp_o <= {rsp_o[46:0], miso_i};
            if (bit_cnt == rsp_last)
            begin
              if (data_flag)
              begin
                fifo_clr_o <= 1'b1;
                tok_cnt    <= '0;
                hunt_q     <= '1;
                state_q    <= TOKEN;
              end
              else
              begin
                cs_o    <= 1'b1;
                done_o  <= 1'b1;
                state_q <= IDLE;
              end
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        TOKEN:
          if (bit_stb)
          begin
            hunt_q <= hunt_nxt;
            if (hunt_nxt == 8'hFE)
            begin
              bit_cnt <= '0;
              state_q <= BLOCK;
            end
            else if (tok_cnt == TOK_W'(`SD_TOKEN_TIMEOUT - 1))
            begin
              cs_o    <= 1'b1;  // Gave up on the card
              done_o  <= 1'b1;
              state_q <= IDLE;
            end
            else
              tok_cnt <= tok_cnt + 1'b1;
          end
        BLOCK:
          if (bit_stb)
          begin
            if (bit_cnt < BIT_W'(BLK_BITS) && bit_cnt[4:0] == 5'd31)
              push_o <= 1'b1;  // Word complete in pack_q next cycle
            // CRC bits are clocked but dropped
            if (bit_cnt == BIT_W'(END_BITS - 1))
            begin
              cs_o    <= 1'b1;
              done_o  <= 1'b1;
              state_q <= IDLE;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        default:
          state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sd_spi_pkg.sv
`default_nettype none

package sd_spi_pkg;

  typedef logic [31:0] sd_word_t;
  typedef logic [63:0] sd_cmd_t;   // [63] data flag, [62:56] rsp bytes, [47:0] frame
  typedef logic [47:0] sd_rsp_t;
  typedef logic [3:0]  sd_sel_t;
  typedef logic [29:0] sd_adr_t;   // Word address

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    sd_adr_t  adr;
    sd_sel_t  sel;
    sd_word_t dat;
  } bus_req_t;

  typedef struct packed {
    logic     ack;
    sd_word_t dat;
  } bus_rsp_t;

  typedef enum sd_adr_t {
    NOOP     = 30'd0,
    SEND     = 30'd1,
    CMD_LO   = 30'd2,
    CMD_HI   = 30'd3,
    RSP_FLAG = 30'd4,
    RSP_LO   = 30'd5,
    RSP_HI   = 30'd6,
    DATA     = 30'd7
  } sd_reg_e;

  typedef enum logic [2:0] {IDLE, CMD, RSP_WAIT, RSP, TOKEN, BLOCK} sd_state_e;

endpackage

`default_nettype wire

//--- sd_spi_tb.sv
`default_nettype none

`include "sd_spi_config.svh"

module sd_spi_tb;
  import sd_spi_pkg::*;

  localparam int WORDS = `SD_BLOCK_BYTES / 4;
  localparam sd_sel_t ALL = 4'hF;

  logic        clk;
  logic        rst;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        miso;
  logic        sck;
  logic        cs;
  logic        mosi;
  logic        data_en;
  logic        no_token;
  logic [2:0]  rsp_len;
  logic [47:0] card_frame;
  logic [47:0] card_rsp;
  sd_word_t    rd;
  int          n;

  sd_spi_tb_clk clk_gen_i (
    .clk_o (clk),
    .rst_o (rst)
  );

  sd_spi_top dut_i (
    .clk    (clk),
    .rst    (rst),
    .bus_i  (req),
    .bus_o  (rsp),
    .miso_i (miso),
    .sck_o  (sck),
    .cs_o   (cs),
    .mosi_o (mosi)
  );

  sd_card_model card_i (
    .clk        (clk),
    .sck_i      (sck),
    .cs_i       (cs),
    .mosi_i     (mosi),
    .data_en_i  (data_en),
    .no_token_i (no_token),
    .rsp_len_i  (rsp_len),
    .miso_o     (miso),
    .frame_o    (card_frame),
    .rsp_o      (card_rsp)
  );

  bind sd_spi_top sd_spi_checker chk_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (bus_i),
    .rsp_i (bus_o),
    .cs_i  (cs_o)
  );

  task automatic expect_word(input sd_word_t got, input sd_word_t exp, input string what);
    assert (got === exp)
    else
    begin
      $display("error: time %0t: %s got %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // One bus cycle, stb dropped on the edge where ack is seen
  task automatic bus_xfer(input logic we, input sd_adr_t adr, input sd_sel_t sel,
                          input sd_word_t wdat, input int limit,
                          output sd_word_t rdat, output int lat);
    int cnt;
    @(posedge clk);
    req.cyc <= 1'b1;
    req.stb <= 1'b1;
    req.we  <= we;
    req.adr <= adr;
    req.sel <= sel;
    req.dat <= wdat;
    cnt = 0;
    do
    begin
      @(posedge clk);
      cnt++;
    end
    while (!rsp.ack && cnt < limit);
    if (!rsp.ack)
      abort_run("timeout waiting for bus ack");
    rdat = rsp.dat;
    lat  = cnt;
    req.cyc <= 1'b0;
    req.stb <= 1'b0;
  endtask

  task automatic write_reg(input sd_adr_t adr, input sd_sel_t sel, input sd_word_t dat);
    sd_word_t d;
    int       lat;
    bus_xfer(1'b1, adr, sel, dat, 20, d, lat);
    expect_word(sd_word_t'(lat), 32'd2, "write ack latency");
  endtask

  task automatic read_reg(input sd_adr_t adr, input sd_sel_t sel, output sd_word_t dat);
    int lat;
    bus_xfer(1'b0, adr, sel, '0, 20, dat, lat);
    expect_word(sd_word_t'(lat), 32'd2, "read ack latency");
  endtask

  task automatic load_cmd(input logic data, input logic [6:0] len, input logic [47:0] frame);
    write_reg(CMD_LO, ALL, frame[31:0]);
    write_reg(CMD_HI, ALL, {data, len, 8'h00, frame[47:32]});
  endtask

  task automatic send_and_check(input logic [47:0] frame, input int limit);
    sd_word_t d;
    int       lat;
    bus_xfer(1'b1, SEND, ALL, '0, limit, d, lat);
    expect_word(sd_word_t'(cs), 32'd1, "cs_o after SEND");
    expect_word(card_frame[31:0], frame[31:0], "captured frame low");
    expect_word({16'h0, card_frame[47:32]}, {16'h0, frame[47:32]}, "captured frame high");
    read_reg(RSP_FLAG, ALL, d);
    expect_word(d, 32'd1, "RSP_FLAG");
    read_reg(RSP_LO, ALL, d);
    expect_word(d, card_rsp[31:0], "RSP_LO");
    read_reg(RSP_HI, ALL, d);
    expect_word(d, {16'h0, card_rsp[47:32]}, "RSP_HI");
  endtask

  initial
  begin
    req      = '0;
    data_en  = 1'b0;
    no_token = 1'b0;
    rsp_len  = 3'd1;
    n        = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (rst && n < 20);
    if (rst)
      abort_run("reset never released");
    expect_word(sd_word_t'(cs), 32'd1, "cs_o after reset");
    expect_word(sd_word_t'(mosi), 32'd1, "mosi_o after reset");
    expect_word(sd_word_t'(sck), 32'd0, "sck_o after reset");
    expect_word(sd_word_t'(rsp.ack), 32'd0, "ack after reset");
    read_reg(NOOP, ALL, rd);
    expect_word(rd, 32'd0, "NOOP read");

    // Byte enable merges on both command halves
    write_reg(CMD_LO, ALL, 32'h11223344);
    write_reg(CMD_LO, 4'b0101, 32'hAABBCCDD);
    read_reg(CMD_LO, ALL, rd);
    expect_word(rd, 32'h11BB33DD, "CMD_LO merge");
    read_reg(CMD_LO, 4'b0011, rd);
    expect_word(rd, 32'h000033DD, "CMD_LO lanes");
    write_reg(CMD_HI, ALL, 32'h01020304);
    write_reg(CMD_HI, 4'b1010, 32'hF0E0D0C0);
    read_reg(CMD_HI, ALL, rd);
    expect_word(rd, 32'hF002D004, "CMD_HI merge");
    write_reg(30'd9, ALL, 32'hDEADBEEF);
    read_reg(30'd9, ALL, rd);
    expect_word(rd, 32'd0, "unmapped read");
    read_reg(SEND, ALL, rd);
    expect_word(rd, 32'd0, "SEND read");

    // Response only, one and five bytes
    rsp_len <= 3'd1;
    load_cmd(1'b0, 7'd1, 48'h400000000095);
    send_and_check(48'h400000000095, 2000);
    rsp_len <= 3'd5;
    load_cmd(1'b0, 7'd5, 48'h48000001AA87);
    send_and_check(48'h48000001AA87, 2000);

    // Block read
    rsp_len <= 3'd1;
    data_en <= 1'b1;
    load_cmd(1'b1, 7'd1, 48'h510000020055);
    send_and_check(48'h510000020055, 40000);
    for (int i = 0; i < WORDS; i++)
    begin
      read_reg(DATA, ALL, rd);
      expect_word(rd, {card_i.blk[4*i+3], card_i.blk[4*i+2],
                       card_i.blk[4*i+1], card_i.blk[4*i]}, "DATA word");
    end
    read_reg(DATA, ALL, rd);
    expect_word(rd, 32'd0, "DATA read past block");

    // Second block stays in the FIFO until the next data command
    load_cmd(1'b1, 7'd1, 48'h510000030011);
    send_and_check(48'h510000030011, 40000);

    // Card never sends the token
    no_token <= 1'b1;
    load_cmd(1'b1, 7'd1, 48'h510000040033);
    send_and_check(48'h510000040033, 10000);
    read_reg(DATA, ALL, rd);
    expect_word(rd, 32'd0, "DATA after token timeout");

    repeat (4) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sd_spi_tb_clk.sv
`default_nettype none

module sd_spi_tb_clk (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #5 clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on a rising edge
  end

endmodule

`default_nettype wire

//--- sd_spi_top.sv
`default_nettype none

module sd_spi_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire sd_spi_pkg::bus_req_t bus_i,
  output sd_spi_pkg::bus_rsp_t      bus_o,
  input  wire                       miso_i,
  output logic                      sck_o,
  output logic                      cs_o,
  output logic                      mosi_o
);
  import sd_spi_pkg::*;

  logic     start;
  logic     done;
  logic     push;
  logic     pop;
  logic     fifo_clr;
  logic     fifo_empty;
  sd_cmd_t  cmd;
  sd_rsp_t  rsp;
  sd_word_t push_word;
  sd_word_t fifo_word;

  sd_bus_regs regs_i (
    .clk          (clk),
    .rst          (rst),
    .bus_i        (bus_i),
    .done_i       (done),
    .rsp_i        (rsp),
    .fifo_word_i  (fifo_word),
    .fifo_empty_i (fifo_empty),
    .bus_o        (bus_o),
    .start_o      (start),
    .cmd_o        (cmd),
    .pop_o        (pop)
  );

  sd_spi_engine engine_i (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start),
    .cmd_i      (cmd),
    .miso_i     (miso_i),
    .done_o     (done),
    .rsp_o      (rsp),
    .push_o     (push),
    .word_o     (push_word),
    .fifo_clr_o (fifo_clr),
    .sck_o      (sck_o),
    .cs_o       (cs_o),
    .mosi_o     (mosi_o)
  );

  sd_block_fifo fifo_i (
    .clk     (clk),
    .rst     (rst),
    .clr_i   (fifo_clr),
    .push_i  (push),
    .word_i  (push_word),
    .pop_i   (pop),
    .word_o  (fifo_word),
    .empty_o (fifo_empty)
  );

endmodule

`default_nettype wire
